/* common/mips_pkg.sv */
package mips_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_W     = 32;
	localparam int REG_AW     = 5;
	localparam int NUM_REGS   = 1 << REG_AW;
	localparam int IMEM_AW    = 6;
	localparam int DMEM_AW    = 6;
	localparam int IMEM_DEPTH = 1 << IMEM_AW;
	localparam int DMEM_DEPTH = 1 << DMEM_AW;

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [REG_AW-1:0]  reg_idx_t;
	typedef logic [IMEM_AW-1:0] imem_addr_t;
	typedef logic [DMEM_AW-1:0] dmem_addr_t;
	typedef logic [5:0]         opcode_t;   // also used for funct

	localparam word_t HALT_WORD = '1;      // all ones stops the core

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	localparam opcode_t FN_ADD = 6'h20;
	localparam opcode_t FN_SUB = 6'h22;
	localparam opcode_t FN_AND = 6'h24;
	localparam opcode_t FN_OR  = 6'h25;
	localparam opcode_t FN_SLT = 6'h2a;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_e;

	typedef enum logic [1:0] {st_load, st_run, st_halted} core_state_e;

	//////////////////////////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;          // sign extended
		word_t    pc_plus4;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		alu_op_e  alu_op;
		logic     alu_src_imm;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     branch;
		logic     halt;
		logic     valid;
	} id_ex_t;

	typedef struct packed {
		word_t    alu_out;
		word_t    store_data;
		word_t    branch_target;
		logic     zero;
		reg_idx_t dest;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     branch;
		logic     halt;
		logic     valid;
	} ex_mem_t;

	typedef struct packed {
		word_t    wb_data;
		reg_idx_t dest;
		logic     reg_write;
		logic     halt;
		logic     valid;
	} mem_wb_t;

	typedef struct packed {
		logic     reg_write;
		reg_idx_t dest;
		word_t    wb_data;
	} wb_t;

endpackage

/* fetch/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 prog_load,
	input  logic                 prog_we,
	input  mips_pkg::imem_addr_t prog_addr,
	input  mips_pkg::word_t      prog_data,
	input  logic                 stall,
	input  logic                 jump_take,
	input  mips_pkg::word_t      jump_target,
	input  logic                 branch_take,
	input  mips_pkg::word_t      branch_target,
	input  logic                 halt_seen,
	output mips_pkg::if_id_t     if_id,
	output mips_pkg::word_t      pc,
	output logic                 halted
);
	import mips_pkg::*;

	core_state_e state;
	core_state_e state_nxt;
	word_t       imem [IMEM_DEPTH];
	imem_addr_t  fetch_idx;
	word_t       instr;
	word_t       pc_plus4;
	word_t       pc_nxt;
	logic        fetch_halt;
	logic        run;

	//////////////////////////////////////////////////////////////////////
	// core run / halt control
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			st_load: begin
				if (!prog_load)
					state_nxt = st_run;
			end
			st_run: begin
				if (prog_load)
					state_nxt = st_load;
				else if (halt_seen)
					state_nxt = st_halted;
			end
			st_halted: begin
				if (prog_load)
					state_nxt = st_load;
			end
			default: state_nxt = st_load;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= st_load;
		else
			state <= state_nxt;
	end

	assign halted = (state == st_halted);
	assign run    = (state == st_run) && !prog_load;

	//////////////////////////////////////////////////////////////////////
	// instruction memory and PC
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (prog_load && prog_we)
			imem[prog_addr] <= prog_data;   // program load port
	end

	assign fetch_idx  = pc[IMEM_AW+1:2];
	assign instr      = imem[fetch_idx];
	assign pc_plus4   = pc + 32'd4;
	assign fetch_halt = (instr == HALT_WORD);   // park on the halt word

	always_comb begin
		if (branch_take)
			pc_nxt = branch_target;
		else if (jump_take)
			pc_nxt = jump_target;
		else if (stall || fetch_halt)
			pc_nxt = pc;
		else
			pc_nxt = pc_plus4;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else if (prog_load)
			pc <= '0;
		else if (run)
			pc <= pc_nxt;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (prog_load || state == st_load) begin
			if_id <= '0;                    // drain while loading
		end else if (run) begin
			if (branch_take || jump_take)
				if_id.valid <= 1'b0;        // squash wrong-path fetch
			else if (!stall)
				if_id <= '{instr: instr, pc_plus4: pc_plus4, valid: 1'b1};
		end
	end

endmodule

/* decode/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  mips_pkg::if_id_t   if_id,
	input  mips_pkg::wb_t      wb,
	input  logic               flush,
	input  logic               halted,
	input  mips_pkg::reg_idx_t dbg_reg_addr,
	output mips_pkg::id_ex_t   id_ex,
	output logic               stall,
	output logic               jump_take,
	output mips_pkg::word_t    jump_target,
	output mips_pkg::word_t    dbg_reg_data
);
	import mips_pkg::*;

	word_t    regs [NUM_REGS];
	word_t    instr;
	opcode_t  opcode;
	opcode_t  funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	word_t    imm_ext;
	logic     is_rtype;
	logic     is_alu_r;
	logic     is_addi;
	logic     is_lw;
	logic     is_sw;
	logic     is_beq;
	logic     is_j;
	logic     is_halt;
	logic     uses_rs;
	logic     uses_rt;
	alu_op_e  alu_op;
	word_t    rs_val;
	word_t    rt_val;
	id_ex_t   dec;

	// register read with write-through from the write-back bundle
	function automatic word_t read_reg(input reg_idx_t idx);
		word_t val;
		if (idx == '0)
			val = '0;
		else if (wb.reg_write && wb.dest == idx)
			val = wb.wb_data;
		else
			val = regs[idx];
		return val;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// instruction fields and control
	//////////////////////////////////////////////////////////////////////

	assign instr   = if_id.instr;
	assign opcode  = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign funct   = instr[5:0];
	assign imm_ext = {{16{instr[15]}}, instr[15:0]};

	assign is_halt  = (instr == HALT_WORD);
	assign is_rtype = (opcode == OP_RTYPE);
	assign is_alu_r = is_rtype && (funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT});
	assign is_addi  = (opcode == OP_ADDI);
	assign is_lw    = (opcode == OP_LW);
	assign is_sw    = (opcode == OP_SW);
	assign is_beq   = (opcode == OP_BEQ);
	assign is_j     = (opcode == OP_J);

	assign uses_rs = is_alu_r || is_addi || is_lw || is_sw || is_beq;
	assign uses_rt = is_alu_r || is_sw || is_beq;

	always_comb begin
		alu_op = alu_add;                   // addi, lw, sw
		if (is_beq) begin
			alu_op = alu_sub;               // zero flag compare
		end else if (is_rtype) begin
			case (funct)
				FN_SUB:  alu_op = alu_sub;
				FN_AND:  alu_op = alu_and;
				FN_OR:   alu_op = alu_or;
				FN_SLT:  alu_op = alu_slt;
				default: alu_op = alu_add;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb.reg_write && wb.dest != '0 && !halted)
			regs[wb.dest] <= wb.wb_data;
	end

	always_comb begin
		rs_val = read_reg(rs);
		rt_val = read_reg(rt);
	end

	assign dbg_reg_data = (dbg_reg_addr == '0) ? '0 : regs[dbg_reg_addr];

	//////////////////////////////////////////////////////////////////////
	// hazards, jump and the ID/EX register
	//////////////////////////////////////////////////////////////////////

	// load in EX feeding this instruction gets one bubble
	assign stall = if_id.valid && id_ex.valid && id_ex.mem_read && id_ex.dest != '0 &&
		((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

	assign jump_take   = if_id.valid && is_j && !flush;
	assign jump_target = {if_id.pc_plus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		dec.rs_val      = rs_val;
		dec.rt_val      = rt_val;
		dec.imm         = imm_ext;
		dec.pc_plus4    = if_id.pc_plus4;
		dec.rs          = rs;
		dec.rt          = rt;
		dec.dest        = is_rtype ? rd : rt;
		dec.alu_op      = alu_op;
		dec.alu_src_imm = is_addi || is_lw || is_sw;
		dec.reg_write   = is_alu_r || is_addi || is_lw;
		dec.mem_read    = is_lw;
		dec.mem_write   = is_sw;
		dec.branch      = is_beq;
		dec.halt        = is_halt;
		dec.valid       = if_id.valid && !stall && !flush;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			id_ex <= '0;
		else if (!halted)
			id_ex <= dec;
	end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  mips_pkg::id_ex_t  id_ex,
	input  mips_pkg::wb_t     wb,
	input  logic              flush,
	input  logic              halted,
	output mips_pkg::ex_mem_t ex_mem
);
	import mips_pkg::*;

	word_t   op_a;
	word_t   op_b_reg;
	word_t   op_b;
	word_t   alu_out;
	ex_mem_t ex_nxt;

	// youngest producer wins, loads in EX/MEM are covered by the stall
	function automatic word_t forward(input reg_idx_t idx, input word_t val);
		word_t res;
		if (idx != '0 && ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
				ex_mem.dest == idx)
			res = ex_mem.alu_out;
		else if (idx != '0 && wb.reg_write && wb.dest == idx)
			res = wb.wb_data;
		else
			res = val;
		return res;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// operands and ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		op_a     = forward(id_ex.rs, id_ex.rs_val);
		op_b_reg = forward(id_ex.rt, id_ex.rt_val);
	end

	assign op_b = id_ex.alu_src_imm ? id_ex.imm : op_b_reg;

	always_comb begin
		case (id_ex.alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(op_b));
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// EX/MEM register
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ex_nxt.alu_out       = alu_out;
		ex_nxt.store_data    = op_b_reg;   // sw data is the forwarded rt
		ex_nxt.branch_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};
		ex_nxt.zero          = (alu_out == '0);
		ex_nxt.dest          = id_ex.dest;
		ex_nxt.reg_write     = id_ex.reg_write;
		ex_nxt.mem_read      = id_ex.mem_read;
		ex_nxt.mem_write     = id_ex.mem_write;
		ex_nxt.branch        = id_ex.branch;
		ex_nxt.halt          = id_ex.halt;
		ex_nxt.valid         = id_ex.valid && !flush;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_mem <= '0;
		else if (!halted)
			ex_mem <= ex_nxt;
	end

endmodule

/* memory/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  mips_pkg::ex_mem_t    ex_mem,
	input  logic                 halted,
	input  mips_pkg::dmem_addr_t dbg_mem_addr,
	output mips_pkg::mem_wb_t    mem_wb,
	output mips_pkg::wb_t        wb,
	output logic                 branch_take,
	output mips_pkg::word_t      branch_target,
	output logic                 halt_seen,
	output mips_pkg::word_t      dbg_mem_data
);
	import mips_pkg::*;

	word_t      dmem [DMEM_DEPTH];
	dmem_addr_t dm_idx;
	word_t      load_data;
	mem_wb_t    wb_nxt;

	//////////////////////////////////////////////////////////////////////
	// data memory
	//////////////////////////////////////////////////////////////////////

	assign dm_idx = ex_mem.alu_out[DMEM_AW+1:2];   // word index

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_write && !halted)
			dmem[dm_idx] <= ex_mem.store_data;
	end

	assign load_data    = dmem[dm_idx];
	assign dbg_mem_data = dmem[dbg_mem_addr];

	// beq taken when operands compared equal in EX
	assign branch_take   = ex_mem.valid && ex_mem.branch && ex_mem.zero;
	assign branch_target = ex_mem.branch_target;

	//////////////////////////////////////////////////////////////////////
	// MEM/WB register and write-back
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		wb_nxt.wb_data   = ex_mem.mem_read ? load_data : ex_mem.alu_out;
		wb_nxt.dest      = ex_mem.dest;
		wb_nxt.reg_write = ex_mem.reg_write;
		wb_nxt.halt      = ex_mem.halt;
		wb_nxt.valid     = ex_mem.valid;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem_wb <= '0;
		else if (!halted)
			mem_wb <= wb_nxt;
	end

	assign wb = '{
		reg_write: mem_wb.valid && mem_wb.reg_write,
		dest:      mem_wb.dest,
		wb_data:   mem_wb.wb_data
	};

	assign halt_seen = mem_wb.valid && mem_wb.halt;   // halt reached write-back

endmodule

/* logic/mips_top.sv */
`timescale 1ns/10ps

module mips_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 prog_load,
	input  logic                 prog_we,
	input  mips_pkg::imem_addr_t prog_addr,
	input  mips_pkg::word_t      prog_data,
	input  mips_pkg::reg_idx_t   dbg_reg_addr,
	input  mips_pkg::dmem_addr_t dbg_mem_addr,
	output mips_pkg::word_t      dbg_reg_data,
	output mips_pkg::word_t      dbg_mem_data,
	output mips_pkg::word_t      pc,
	output logic                 halted
);
	import mips_pkg::*;

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	wb_t     wb;
	logic    stall;
	logic    jump_take;
	word_t   jump_target;
	logic    branch_take;
	word_t   branch_target;
	logic    halt_seen;

	//////////////////////////////////////////////////////////////////////
	// pipeline stages
	//////////////////////////////////////////////////////////////////////

	fetch_stage fetch_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.prog_load     (prog_load),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.stall         (stall),
		.jump_take     (jump_take),
		.jump_target   (jump_target),
		.branch_take   (branch_take),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.if_id         (if_id),
		.pc            (pc),
		.halted        (halted)
	);

	decode_stage decode_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.if_id        (if_id),
		.wb           (wb),
		.flush        (branch_take),   // beq resolved in MEM
		.halted       (halted),
		.dbg_reg_addr (dbg_reg_addr),
		.id_ex        (id_ex),
		.stall        (stall),
		.jump_take    (jump_take),
		.jump_target  (jump_target),
		.dbg_reg_data (dbg_reg_data)
	);

	execute_stage execute_i (
		.clk    (clk),
		.arst_n (arst_n),
		.id_ex  (id_ex),
		.wb     (wb),
		.flush  (branch_take),
		.halted (halted),
		.ex_mem (ex_mem)
	);

	memory_stage memory_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.ex_mem        (ex_mem),
		.halted        (halted),
		.dbg_mem_addr  (dbg_mem_addr),
		.mem_wb        (mem_wb),
		.wb            (wb),
		.branch_take   (branch_take),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.dbg_mem_data  (dbg_mem_data)
	);

endmodule

/* dv/mips_asserts.sv */
`timescale 1ns/10ps

module mips_asserts (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  prog_load,
	input logic                  halted,
	input logic                  stall,
	input logic                  branch_take,
	input mips_pkg::core_state_e state,
	input mips_pkg::wb_t         wb,
	input mips_pkg::reg_idx_t    dbg_reg_addr,
	input mips_pkg::word_t       dbg_reg_data,
	input mips_pkg::word_t       pc
);
	import mips_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// pipeline control rules
	//////////////////////////////////////////////////////////////////////

	hazard_in_run: assert property (@(posedge clk) disable iff (!arst_n)
		(stall || branch_take) |-> (state == st_run))
		else $error("stall or branch_take seen outside st_run");

	halted_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(halted) |-> $past(prog_load))   // only a reload clears it
		else $error("halted fell without a program load");

	// a write aimed at register 0 leaves the read-out unchanged
	reg0_write_dropped: assert property (@(posedge clk) disable iff (!arst_n)
		(wb.reg_write && wb.dest == '0) |=>
		(!$stable(dbg_reg_addr) || $stable(dbg_reg_data)))
		else $error("write to register 0 changed the register read-out");

	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00)
		else $error("pc is not word aligned");

endmodule

/* dv/mips_tb.sv */
`timescale 1ns/10ps

module mips_tb;
	import mips_pkg::*;

	localparam int MAX_CHECKS  = 64;
	localparam int RUN_LIMIT   = 2000;   // cycles allowed per program
	localparam int HOLD_CYCLES = 8;      // cycles watched after halt

	logic       clk;
	logic       arst_n;
	logic       prog_load;
	logic       prog_we;
	imem_addr_t prog_addr;
	word_t      prog_data;
	reg_idx_t   dbg_reg_addr;
	dmem_addr_t dbg_mem_addr;
	word_t      dbg_reg_data;
	word_t      dbg_mem_data;
	word_t      pc;
	logic       halted;

	integer           seed;
	integer           fd;
	logic [8*32-1:0]  tok;
	logic [8*160-1:0] line;
	string            test_name;
	word_t            prog [IMEM_DEPTH];
	int               nwords;
	logic             chk_mem [MAX_CHECKS];
	int               chk_idx [MAX_CHECKS];
	word_t            chk_val [MAX_CHECKS];
	int               num_checks;
	int               tests_run;

	mips_top dut_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.prog_load    (prog_load),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_mem_addr (dbg_mem_addr),
		.dbg_reg_data (dbg_reg_data),
		.dbg_mem_data (dbg_mem_data),
		.pc           (pc),
		.halted       (halted)
	);

	bind mips_top mips_asserts asserts_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.prog_load    (prog_load),
		.halted       (halted),
		.stall        (stall),
		.branch_take  (branch_take),
		.state        (fetch_i.state),
		.wb           (wb),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.pc           (pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// checking helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input int idx, input word_t exp,
			input word_t got);
		assert (got === exp) else begin
			$display("[ERROR] %s: %s %0d expected %h actual %h", test_name, what, idx, exp, got);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// one test: load, run to halt, read back
	//////////////////////////////////////////////////////////////////////

	task automatic load_program();
		int    a;
		word_t fill;
		@(posedge clk);
		prog_load <= 1'b1;
		for (a = 0; a < IMEM_DEPTH; a++) begin
			if (a < nwords)
				fill = prog[a];
			else if ($random(seed) & 1)   // tail of halts and nops
				fill = HALT_WORD;
			else
				fill = '0;
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= imem_addr_t'(a);
			prog_data <= fill;
		end
		@(posedge clk);
		prog_we <= 1'b0;
		@(negedge clk);
		check_value("pc before run", 0, '0, pc);
		@(posedge clk);
		prog_load <= 1'b0;
	endtask

	task automatic wait_for_halt();
		int    cycles;
		word_t pc_halt;
		cycles = 0;
		while (halted !== 1'b1 && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1)
			stop_on_error($sformatf("test %s did not halt within %0d cycles",
				test_name, RUN_LIMIT));
		pc_halt = pc;
		for (cycles = 0; cycles < HOLD_CYCLES; cycles++) begin
			@(negedge clk);
			check_value("halted", 0, 32'd1, word_t'(halted));
			check_value("pc after halt", 0, pc_halt, pc);   // frozen core
		end
	endtask

	task automatic check_results();
		int i;
		for (i = 0; i < num_checks; i++) begin
			@(posedge clk);
			if (chk_mem[i])
				dbg_mem_addr <= dmem_addr_t'(chk_idx[i]);
			else
				dbg_reg_addr <= reg_idx_t'(chk_idx[i]);
			@(negedge clk);
			if (chk_mem[i])
				check_value("mem", chk_idx[i], chk_val[i], dbg_mem_data);
			else
				check_value("reg", chk_idx[i], chk_val[i], dbg_reg_data);
		end
	endtask

	// keyword driven reader for the test file
	task automatic run_all_tests();
		string kw;
		word_t word;
		int    idx;
		int    n;
		int    i;
		logic  done;
		done = 1'b0;
		while (!done) begin
			tok = '0;
			n = $fscanf(fd, "%s", tok);
			kw = string'(tok);
			if (n != 1) begin
				done = 1'b1;
			end else if (kw.substr(0, 0) == "#") begin
				n = $fgets(line, fd);   // skip comment text
			end else if (kw == "test") begin
				n = $fscanf(fd, "%s %d", tok, nwords);
				test_name = string'(tok);
				if (nwords > IMEM_DEPTH)
					stop_on_error($sformatf("test %s has too many words", test_name));
				for (i = 0; i < nwords; i++) begin
					n = $fscanf(fd, "%h", word);
					prog[i] = word;
				end
				num_checks = 0;
			end else if (kw == "reg" || kw == "mem") begin
				if (num_checks == MAX_CHECKS)
					stop_on_error($sformatf("test %s has too many checks", test_name));
				n = $fscanf(fd, "%d %h", idx, word);
				chk_mem[num_checks] = (kw == "mem");
				chk_idx[num_checks] = idx;
				chk_val[num_checks] = word;
				num_checks++;
			end else if (kw == "end") begin
				load_program();
				wait_for_halt();
				check_results();
				tests_run++;
				$display("test %s checked", test_name);
			end else begin
				stop_on_error($sformatf("unknown keyword %s in test file", kw));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed         = 32'h6286;
		arst_n       <= 1'b0;
		prog_load    <= 1'b1;   // keeps the core parked after reset
		prog_we      <= 1'b0;
		prog_addr    <= '0;
		prog_data    <= '0;
		dbg_reg_addr <= '0;
		dbg_mem_addr <= '0;
		nwords       = 0;
		num_checks   = 0;
		tests_run    = 0;
		test_name    = "none";
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		fd = $fopen("dv/mips_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/mips_tests.txt");
			$display("Simulation FAILED");
			$fatal(1, "no test file");
		end else begin
			run_all_tests();
			$fclose(fd);
			if (tests_run > 0) begin
				$display("Simulation PASSED");
				$finish;
			end else begin
				$display("no test found in dv/mips_tests.txt");
				$display("Simulation FAILED");
				$fatal(1, "empty test file");
			end
		end
	end

endmodule

/* dv/mips_tests.txt */
# test <name> <word count>, followed by the program as hex words from address 0
# reg|mem <index> <expected hex value> lines, then end loads and runs the test
test alu 11
20010007 2002fffd 00221820 00222022
00222824 00223025 0041382a 0022402a
20200005 00014820 ffffffff
reg 0 00000000  reg 1 00000007  reg 2 fffffffd  reg 3 00000004
reg 4 0000000a  reg 5 00000005  reg 6 ffffffff  reg 7 00000001
reg 8 00000000  reg 9 00000007
end
test forward 8
20010005 20220003 00221820 00612022
00832820 00a43025 00c63020 ffffffff
reg 1 00000005  reg 2 00000008  reg 3 0000000d
reg 4 00000008  reg 5 00000015  reg 6 0000003a
end
test memory 13
20070000 20011234 20020008 ac410004
8c430004 00632020 20e70001 20850001
ac050000 8c060000 ac460008 20e70001
ffffffff
reg 1 00001234  reg 2 00000008  reg 3 00001234  reg 4 00002468
reg 5 00002469  reg 6 00002469  reg 7 00000002
mem 3 00001234  mem 0 00002469  mem 4 00002469
end
test branch 16
20060000 20010001 20020001 20030000
10220003 20630001 20630002 20630004
10200002 20040005 20050006 0800000d
20060009 20070003 00644020 ffffffff
reg 1 00000001  reg 2 00000001  reg 3 00000000  reg 4 00000005
reg 5 00000006  reg 6 00000000  reg 7 00000003  reg 8 00000005
end
test reload 4
20010055 ac010010 00000000 ffffffff
reg 0 00000000  reg 1 00000055  mem 4 00000055
end

/* verilog.f */
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
logic/mips_top.sv
dv/mips_asserts.sv
dv/mips_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the MIPS pipeline testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module mips_tb -o mips_sim &&
./obj_dir/mips_sim || {
	echo "build or simulation returned an error"
	exit 1
}
